// ==== hw/apu_bus_pkg.sv ====
package apu_bus_pkg;

	// host side register bus, one transaction in flight

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	typedef struct packed {
		bus_op_e    op;
		logic [7:0] addr;  // offset within the sound unit window
		logic [7:0] wdata; // ignored on reads
	} bus_req_t;

	typedef struct packed {
		logic [7:0] rdata; // meaningless on write responses
		logic       hit;   // address matched NR50..NR52
	} bus_resp_t;

	// data field returned with a write acknowledge
	localparam logic [7:0] WR_RESP_DATA = 8'h00;

endpackage

// ==== hw/apu_reg_pkg.sv ====
package apu_reg_pkg;

	localparam logic [7:0] ADDR_NR50 = 8'h24; // master volume
	localparam logic [7:0] ADDR_NR51 = 8'h25; // panning
	localparam logic [7:0] ADDR_NR52 = 8'h26; // power and status

	typedef enum logic [1:0] {
		SEL_NONE,
		SEL_NR50,
		SEL_NR51,
		SEL_NR52
	} reg_sel_e;

	typedef struct packed {
		logic       vin_l; // external input to left, not mixed here
		logic [2:0] vol_l;
		logic       vin_r;
		logic [2:0] vol_r;
	} nr50_t;

	// bit n of each nibble is channel n+1
	typedef struct packed {
		logic [3:0] left_en;
		logic [3:0] right_en;
	} nr51_t;

	typedef struct packed {
		logic       strobe;
		reg_sel_e   sel;
		logic [7:0] data;
	} reg_wr_t;

	localparam nr50_t NR50_RST = '0;
	localparam nr51_t NR51_RST = '0;

	localparam int         PWR_BIT     = 7;      // NR52 master enable
	localparam logic [2:0] NR52_UNUSED = 3'b111; // always read back set
	localparam logic [7:0] RD_UNMAPPED = 8'hFF;  // open bus value

endpackage

// ==== hw/apu_bus_port.sv ====
`timescale 1ns/1ps

module apu_bus_port (
	input  logic                   apuv_4mhz,
	input  logic                   rst,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  apu_bus_pkg::bus_req_t  req,
	output logic                   resp_valid,
	input  logic                   resp_ready,
	output apu_bus_pkg::bus_resp_t resp,
	output apu_reg_pkg::reg_wr_t   wr,
	output apu_reg_pkg::reg_sel_e  rd_sel,
	input  logic [7:0]             rd_data
);
	import apu_bus_pkg::*;
	import apu_reg_pkg::*;

	reg_sel_e sel;
	logic     accept;
	logic     is_write;

	always_comb begin
		case (req.addr)
			ADDR_NR50: sel = SEL_NR50;
			ADDR_NR51: sel = SEL_NR51;
			ADDR_NR52: sel = SEL_NR52;
			default:   sel = SEL_NONE;
		endcase
	end

	assign req_ready = !resp_valid; // stall until the response is taken
	assign accept    = req_valid && req_ready;
	assign is_write  = (req.op == OP_WRITE);

	always_comb begin
		if (accept && !is_write) begin
			rd_sel = sel; // control answers in the same cycle
		end else begin
			rd_sel = SEL_NONE;
		end
	end

	always_ff @(posedge apuv_4mhz) begin
		if (rst) begin
			resp_valid <= 1'b0;
		end else if (accept) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0;
		end
	end

	// held until the host pops it
	always_ff @(posedge apuv_4mhz) begin
		if (accept) begin
			resp.hit   <= (sel != SEL_NONE);
			resp.rdata <= is_write ? WR_RESP_DATA : rd_data;
		end
	end

	always_ff @(posedge apuv_4mhz) begin
		if (rst) begin
			wr.strobe <= 1'b0;
		end else begin
			wr.strobe <= accept && is_write; // single cycle pulse
			if (accept) begin
				wr.sel  <= sel;
				wr.data <= req.wdata;
			end
		end
	end

endmodule

// ==== hw/apu_control.sv ====
`timescale 1ns/1ps

module apu_control (
	input  logic                  apuv_4mhz,
	input  logic                  rst,
	input  apu_reg_pkg::reg_wr_t  wr,
	input  apu_reg_pkg::reg_sel_e rd_sel,
	input  logic [3:0]            ch_active,
	output logic [7:0]            rd_data,
	output logic                  power,
	output apu_reg_pkg::nr50_t    nr50,
	output apu_reg_pkg::nr51_t    nr51
);
	import apu_reg_pkg::*;

	logic       wr_nr50;
	logic       wr_nr51;
	logic       wr_nr52;
	logic       pwr_down;
	logic [3:0] ch_bits;

	// NR50/NR51 are locked while the unit is powered down
	assign wr_nr50 = wr.strobe && (wr.sel == SEL_NR50) && power;
	assign wr_nr51 = wr.strobe && (wr.sel == SEL_NR51) && power;
	assign wr_nr52 = wr.strobe && (wr.sel == SEL_NR52);

	assign pwr_down = wr_nr52 && !wr.data[PWR_BIT];

	always_ff @(posedge apuv_4mhz) begin
		if (rst) begin
			power <= 1'b0;
		end else if (wr_nr52) begin
			power <= wr.data[PWR_BIT]; // only bit 7 is writable
		end
	end

	always_ff @(posedge apuv_4mhz) begin
		if (rst || pwr_down) begin
			nr50 <= NR50_RST;
		end else if (wr_nr50) begin
			nr50 <= nr50_t'(wr.data);
		end
	end

	always_ff @(posedge apuv_4mhz) begin
		if (rst || pwr_down) begin
			nr51 <= NR51_RST;
		end else if (wr_nr51) begin
			nr51 <= nr51_t'(wr.data);
		end
	end

	// status bits are meaningless with the unit off
	assign ch_bits = power ? ch_active : 4'h0;

	always_comb begin
		case (rd_sel)
			SEL_NR50: rd_data = nr50;
			SEL_NR51: rd_data = nr51;
			SEL_NR52: rd_data = {power, NR52_UNUSED, ch_bits};
			default:  rd_data = RD_UNMAPPED;
		endcase
	end

endmodule

// ==== hw/apu_clock_div.sv ====
`timescale 1ns/1ps

module apu_clock_div #(
	parameter int FRAME_DIV = 8192
) (
	input  logic       apuv_4mhz,
	input  logic       rst,
	input  logic       power,
	output logic       en_2mhz,
	output logic       en_1mhz,
	output logic       frame_tick,
	output logic [2:0] frame_step
);
	localparam int               CNT_W    = $clog2(FRAME_DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_DIV - 1);

	logic [1:0]       pre;
	logic [CNT_W-1:0] frame_cnt;

	always_ff @(posedge apuv_4mhz) begin
		if (rst || !power) begin
			pre <= 2'd0;
		end else begin
			pre <= pre + 2'd1;
		end
	end

	assign en_2mhz = pre[0]; // every second cycle
	assign en_1mhz = &pre;   // every fourth cycle

	// power term keeps the tick quiet in the cycle power drops
	assign frame_tick = power && (frame_cnt == CNT_LAST);

	always_ff @(posedge apuv_4mhz) begin
		if (rst || !power) begin
			frame_cnt <= '0;
		end else if (frame_tick) begin
			frame_cnt <= '0;
		end else begin
			frame_cnt <= frame_cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge apuv_4mhz) begin
		if (rst || !power) begin
			frame_step <= 3'd0;
		end else if (frame_tick) begin
			frame_step <= frame_step + 3'd1; // wraps after step 7
		end
	end

endmodule

// ==== hw/apu_mixer.sv ====
`timescale 1ns/1ps

module apu_mixer #(
	parameter int SAMPLE_W = 4
) (
	input  logic                     apuv_4mhz,
	input  logic                     rst,
	input  logic                     power,
	input  apu_reg_pkg::nr50_t       nr50,
	input  apu_reg_pkg::nr51_t       nr51,
	input  logic [3:0][SAMPLE_W-1:0] sample,
	output logic [SAMPLE_W+5:0]      left,
	output logic [SAMPLE_W+5:0]      right
);
	localparam int SUM_W = SAMPLE_W + 2; // four channels add two bits
	localparam int OUT_W = SAMPLE_W + 6; // gain up to 8 adds three more

	logic [SUM_W-1:0] sum_l;
	logic [SUM_W-1:0] sum_r;
	logic [3:0]       gain_l;
	logic [3:0]       gain_r;
	logic [OUT_W-1:0] mix_l;
	logic [OUT_W-1:0] mix_r;

	function automatic logic [SUM_W-1:0] pan_sum(
		input logic [3:0]               en,
		input logic [3:0][SAMPLE_W-1:0] s
	);
		logic [SUM_W-1:0] acc;
		acc = '0;
		for (int i = 0; i < 4; i++) begin
			if (en[i]) begin
				acc = acc + SUM_W'(s[i]);
			end
		end
		return acc;
	endfunction

	assign sum_l = pan_sum(nr51.left_en, sample);
	assign sum_r = pan_sum(nr51.right_en, sample);

	// volume field 0..7 means gain 1..8
	assign gain_l = {1'b0, nr50.vol_l} + 4'd1;
	assign gain_r = {1'b0, nr50.vol_r} + 4'd1;

	assign mix_l = OUT_W'(sum_l) * OUT_W'(gain_l);
	assign mix_r = OUT_W'(sum_r) * OUT_W'(gain_r);

	always_ff @(posedge apuv_4mhz) begin
		if (rst || !power) begin
			left  <= '0; // silent when powered down
			right <= '0;
		end else begin
			left  <= mix_l;
			right <= mix_r;
		end
	end

endmodule

// ==== hw/apu_top.sv ====
`timescale 1ns/1ps

module apu_top #(
	parameter int FRAME_DIV = 8192,
	parameter int SAMPLE_W  = 4
) (
	input  logic                     apuv_4mhz,
	input  logic                     rst,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  apu_bus_pkg::bus_req_t    req,
	output logic                     resp_valid,
	input  logic                     resp_ready,
	output apu_bus_pkg::bus_resp_t   resp,
	input  logic [3:0]               ch_active,
	input  logic [3:0][SAMPLE_W-1:0] sample,
	output logic [SAMPLE_W+5:0]      left,
	output logic [SAMPLE_W+5:0]      right,
	output logic                     en_2mhz,
	output logic                     en_1mhz,
	output logic                     frame_tick,
	output logic [2:0]               frame_step
);
	import apu_reg_pkg::*;

	reg_wr_t    wr;
	reg_sel_e   rd_sel;
	logic [7:0] rd_data;
	logic       power;
	nr50_t      nr50;
	nr51_t      nr51;

	apu_bus_port u_bus_port (
		.apuv_4mhz  (apuv_4mhz),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req        (req),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp),
		.wr         (wr),
		.rd_sel     (rd_sel),
		.rd_data    (rd_data)
	);

	apu_control u_control (
		.apuv_4mhz (apuv_4mhz),
		.rst       (rst),
		.wr        (wr),
		.rd_sel    (rd_sel),
		.ch_active (ch_active),
		.rd_data   (rd_data),
		.power     (power),
		.nr50      (nr50),
		.nr51      (nr51)
	);

	apu_clock_div #(
		.FRAME_DIV (FRAME_DIV)
	) u_clock_div (
		.apuv_4mhz  (apuv_4mhz),
		.rst        (rst),
		.power      (power),
		.en_2mhz    (en_2mhz),
		.en_1mhz    (en_1mhz),
		.frame_tick (frame_tick),
		.frame_step (frame_step)
	);

	apu_mixer #(
		.SAMPLE_W (SAMPLE_W)
	) u_mixer (
		.apuv_4mhz (apuv_4mhz),
		.rst       (rst),
		.power     (power),
		.nr50      (nr50),
		.nr51      (nr51),
		.sample    (sample),
		.left      (left),
		.right     (right)
	);

endmodule

// ==== testbench/apu_props.sv ====
`timescale 1ns/1ps

module apu_props (
	input logic                   apuv_4mhz,
	input logic                   rst,
	input logic                   req_ready,
	input logic                   resp_valid,
	input logic                   resp_ready,
	input apu_bus_pkg::bus_resp_t resp,
	input logic                   power,
	input logic                   frame_tick
);
	resp_hold: assert property (@(posedge apuv_4mhz) disable iff (rst)
		resp_valid && !resp_ready |=> $stable(resp))
		else $error("resp changed while the host was stalling");

	// single transaction in flight
	no_accept_pending: assert property (@(posedge apuv_4mhz) disable iff (rst)
		resp_valid |-> !req_ready)
		else $error("req_ready high while a response is pending");

	quiet_when_off: assert property (@(posedge apuv_4mhz) disable iff (rst)
		!power |-> !frame_tick)
		else $error("frame_tick pulsed with power off");

endmodule

bind apu_top apu_props u_props (
	.apuv_4mhz  (apuv_4mhz),
	.rst        (rst),
	.req_ready  (req_ready),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready),
	.resp       (resp),
	.power      (power),
	.frame_tick (frame_tick)
);

// ==== testbench/apu_tb.sv ====
`timescale 1ns/1ps

module apu_tb;
	import apu_bus_pkg::*;
	import apu_reg_pkg::*;

	localparam int FRAME_DIV  = 16;
	localparam int SAMPLE_W   = 4;
	localparam int MAX_CYCLES = 5000; // about ten times the full test sequence

	logic                     apuv_4mhz;
	logic                     rst;
	logic                     req_valid;
	logic                     req_ready;
	bus_req_t                 req;
	logic                     resp_valid;
	logic                     resp_ready;
	bus_resp_t                resp;
	logic [3:0]               ch_active;
	logic [3:0][SAMPLE_W-1:0] sample;
	logic [SAMPLE_W+5:0]      left;
	logic [SAMPLE_W+5:0]      right;
	logic                     en_2mhz;
	logic                     en_1mhz;
	logic                     frame_tick;
	logic [2:0]               frame_step;
	int                       cycles = 0;

	apu_top #(.FRAME_DIV(FRAME_DIV), .SAMPLE_W(SAMPLE_W)) u_apu_top (.*);

	initial begin
		apuv_4mhz = 1'b0;
		forever #50 apuv_4mhz = ~apuv_4mhz; // 100 ns period
	end

	always @(posedge apuv_4mhz) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] side_mix(input logic [3:0] en, input logic [2:0] vol,
			input logic [3:0][SAMPLE_W-1:0] s);
		int acc;
		acc = 0;
		for (int i = 0; i < 4; i++) begin
			if (en[i]) begin
				acc += int'(s[i]); // bit i enables channel i+1
			end
		end
		return 32'(acc * (int'(vol) + 1));
	endfunction

	// one full request/response exchange, resp_ready held low for stall cycles
	task automatic bus_xfer(input bus_op_e op, input logic [7:0] addr, input logic [7:0] data,
			input int stall, output bus_resp_t rsp);
		@(posedge apuv_4mhz);
		req_valid <= 1'b1;
		req       <= '{op: op, addr: addr, wdata: data};
		@(negedge apuv_4mhz);
		while (!req_ready) begin
			@(negedge apuv_4mhz);
		end
		@(posedge apuv_4mhz); // accepted on this edge
		req_valid <= 1'b0;
		@(negedge apuv_4mhz);
		while (!resp_valid) begin
			@(negedge apuv_4mhz);
		end
		rsp = resp;
		repeat (stall) begin
			@(negedge apuv_4mhz);
			check(32'(resp), 32'(rsp), "response changed under back-pressure");
			check(32'(req_ready), 32'd0, "req_ready high with a response pending");
		end
		@(posedge apuv_4mhz);
		resp_ready <= 1'b1;
		@(posedge apuv_4mhz); // response taken
		resp_ready <= 1'b0;
		@(negedge apuv_4mhz);
		check(32'(resp_valid), 32'd0, "resp_valid still high after transfer");
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
		bus_resp_t rsp;
		bus_xfer(OP_WRITE, addr, data, 0, rsp);
		check(32'(rsp.hit), 32'(addr inside {8'h24, 8'h25, 8'h26}), "write hit flag");
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [7:0] exp, input int stall,
			input string what);
		bus_resp_t rsp;
		bus_xfer(OP_READ, addr, 8'h00, stall, rsp);
		check(32'(rsp.rdata), 32'(exp), what);
		check(32'(rsp.hit), 32'(addr inside {8'h24, 8'h25, 8'h26}), "read hit flag");
	endtask

	task automatic reset_test();
		check(32'(req_ready), 32'd1, "req_ready after reset");
		check(32'(resp_valid), 32'd0, "resp_valid after reset");
		check(32'({left, right}), 32'd0, "mixer output after reset");
		read_expect(ADDR_NR50, 8'h00, 0, "NR50 after reset");
		read_expect(ADDR_NR51, 8'h00, 0, "NR51 after reset");
		read_expect(ADDR_NR52, 8'h70, 0, "NR52 with power off");
		read_expect(8'h30, 8'hFF, 0, "unmapped offset");
	endtask

	task automatic power_test();
		logic [7:0] v50;
		logic [7:0] v51;
		bus_write(ADDR_NR52, 8'h80);
		read_expect(ADDR_NR52, {4'hF, ch_active}, 0, "NR52 with power on");
		for (int i = 0; i < 6; i++) begin
			v50 = 8'($urandom);
			v51 = 8'($urandom);
			bus_write(ADDR_NR50, v50);
			bus_write(ADDR_NR51, v51);
			read_expect(ADDR_NR50, v50, $urandom_range(1, 6), "NR50 readback");
			read_expect(ADDR_NR51, v51, $urandom_range(1, 6), "NR51 readback");
		end
		@(posedge apuv_4mhz);
		ch_active <= 4'b0110;
		read_expect(ADDR_NR52, 8'hF6, 3, "NR52 channel bits");
	endtask

	task automatic poweroff_test();
		bus_write(ADDR_NR50, 8'h77);
		bus_write(ADDR_NR51, 8'hFF);
		bus_write(ADDR_NR52, 8'h00);
		read_expect(ADDR_NR50, 8'h00, 0, "NR50 cleared by power-off");
		read_expect(ADDR_NR51, 8'h00, 0, "NR51 cleared by power-off");
		read_expect(ADDR_NR52, 8'h70, 0, "NR52 after power-off");
		bus_write(ADDR_NR50, 8'h35);
		bus_write(ADDR_NR51, 8'h5A);
		read_expect(ADDR_NR50, 8'h00, 0, "NR50 write while off");
		read_expect(ADDR_NR51, 8'h00, 0, "NR51 write while off");
		bus_write(ADDR_NR52, 8'h80);
		bus_write(ADDR_NR50, 8'h35);
		bus_write(ADDR_NR51, 8'h5A);
		read_expect(ADDR_NR50, 8'h35, 2, "NR50 after power restored");
		read_expect(ADDR_NR51, 8'h5A, 2, "NR51 after power restored");
	endtask

	task automatic mix_test();
		logic [7:0]               v50;
		logic [7:0]               v51;
		logic [3:0][SAMPLE_W-1:0] s;
		for (int i = 0; i < 8; i++) begin
			v50 = (i == 7) ? 8'h77 : 8'($urandom); // last pass is full scale
			v51 = (i == 7) ? 8'hFF : 8'($urandom);
			s   = (i == 7) ? 16'hFFFF : 16'($urandom);
			bus_write(ADDR_NR50, v50);
			bus_write(ADDR_NR51, v51);
			@(posedge apuv_4mhz);
			sample <= s;
			@(posedge apuv_4mhz); // mixer registers here
			@(negedge apuv_4mhz);
			check(32'(left), side_mix(v51[7:4], v50[6:4], s), "left mix");
			check(32'(right), side_mix(v51[3:0], v50[2:0], s), "right mix");
		end
		bus_write(ADDR_NR52, 8'h00);
		@(posedge apuv_4mhz);
		@(negedge apuv_4mhz);
		check(32'({left, right}), 32'd0, "mixer output with power off");
	endtask

	task automatic clkdiv_test();
		int         last_tick;
		int         n_1mhz;
		int         n_2mhz;
		int         n_ticks;
		logic       prev_2mhz;
		logic [2:0] step_exp;
		last_tick = -1;
		n_1mhz    = 0;
		n_2mhz    = 0;
		n_ticks   = 0;
		prev_2mhz = 1'b0;
		step_exp  = 3'd0;
		bus_write(ADDR_NR52, 8'h80);
		for (int c = 0; c < 200; c++) begin
			@(negedge apuv_4mhz);
			check(32'(frame_step), 32'(step_exp), "frame_step sequence");
			if (c > 0) begin
				check(32'(en_2mhz), 32'(!prev_2mhz), "en_2mhz not toggling each cycle");
			end
			prev_2mhz = en_2mhz;
			n_2mhz += int'(en_2mhz);
			n_1mhz += int'(en_1mhz);
			if (frame_tick) begin
				if (last_tick >= 0) begin
					check(32'(c - last_tick), 32'(FRAME_DIV), "frame_tick spacing");
				end
				last_tick = c;
				n_ticks++;
				step_exp = step_exp + 3'd1; // wraps past 7
			end
		end
		check(32'(n_2mhz), 32'd100, "en_2mhz count over 200 cycles");
		check(32'(n_1mhz), 32'd50, "en_1mhz count over 200 cycles");
		check(32'(n_ticks >= 12), 32'd1, "too few frame ticks");
		bus_write(ADDR_NR52, 8'h00);
		@(posedge apuv_4mhz);
		@(negedge apuv_4mhz);
		check(32'(frame_step), 32'd0, "frame_step after power-off");
		check(32'(frame_tick), 32'd0, "frame_tick after power-off");
		check(32'(en_2mhz), 32'd0, "en_2mhz after power-off");
		check(32'(en_1mhz), 32'd0, "en_1mhz after power-off");
	endtask

	initial begin
		void'($urandom(46117));
		rst        = 1'b1;
		req_valid  = 1'b0;
		req        = '0;
		resp_ready = 1'b0;
		ch_active  = 4'b1011;
		sample     = '0;
		repeat (8) @(posedge apuv_4mhz);
		rst <= 1'b0;
		@(negedge apuv_4mhz);
		reset_test();
		power_test();
		poweroff_test();
		mix_test();
		clkdiv_test();
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== src.f ====
hw/apu_bus_pkg.sv
hw/apu_reg_pkg.sv
hw/apu_bus_port.sv
hw/apu_control.sv
hw/apu_clock_div.sv
hw/apu_mixer.sv
hw/apu_top.sv
testbench/apu_props.sv
testbench/apu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module apu_tb -Mdir obj_dir -f src.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vapu_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
